// File: common/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// byte address on the shared bus
`define MEM_ADDR_W 32

// one bus word
`define MEM_DATA_W 32

// client request tag, wide enough to carry a pc or an instruction count
`define MEM_ID_W 32

`endif

// File: common/bus_pkg.sv
package bus_pkg;

    // transfer size, same encoding as the sram-like size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_t;

    // current owner of the shared bus
    typedef enum logic [1:0] {
        GRANT_NONE = 2'b00,
        GRANT_INST = 2'b01,
        GRANT_DATA = 2'b10
    } grant_t;

endpackage

// File: common/exc_pkg.sv
package exc_pkg;

    // status returned alongside every bus response
    typedef enum logic [1:0] {
        NO_EXC   = 2'b00,
        // misaligned for the transfer size
        ADDR_ERR = 2'b01,
        // slave could not serve the address
        BUS_ERR  = 2'b10
    } mem_exc_t;

endpackage

// File: mem_port/sram_handshake.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module sram_handshake (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 need,
    input  logic [`MEM_ID_W-1:0] id,
    input  logic                 addr_ok,
    input  logic                 data_ok,
    output logic                 req,
    output logic                 busy
);

    typedef enum logic {
        IDLE,
        WAIT_DATA
    } state_t;

    state_t               state;
    state_t               state_next;
    logic [`MEM_ID_W-1:0] served_id;
    logic                 served_valid;
    logic                 already_served;
    logic                 done;

    // same id still asserted by a stalled client
    assign already_served = served_valid && (served_id == id);
    assign done           = (state == WAIT_DATA) && data_ok;

    assign req  = (state == IDLE) && need && !already_served;
    assign busy = req || ((state == WAIT_DATA) && !data_ok);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req && addr_ok) begin
                    state_next = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (data_ok) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= IDLE;
            served_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (done) begin
                served_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            served_id <= id;
        end
    end

    // client keeps need and id up, so req must survive until accepted
    property req_held_to_addr_ok;
        @(posedge clk) disable iff (!resetn)
            req && !addr_ok |=> req;
    endproperty
    assert property (req_held_to_addr_ok)
        else $error("sram_handshake: req dropped before addr_ok");

    // arbiter only routes data_ok to a port with an accepted address
    property no_data_ok_in_idle;
        @(posedge clk) disable iff (!resetn)
            (state == IDLE) |-> !data_ok;
    endproperty
    assert property (no_data_ok_in_idle)
        else $error("sram_handshake: data_ok with no request outstanding");

endmodule

// File: mem_port/resp_latch.sv
`timescale 1ns/1ps

module resp_latch #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     stall,
    input  logic     flush,
    input  logic     data_ok,
    input  payload_t in,
    output payload_t out
);

    payload_t held;

    // response goes straight out in the data_ok cycle
    assign out = data_ok ? in : held;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            held <= payload_t'('0);
        end else if (data_ok) begin
            held <= in;
        end else if (!stall) begin
            // stage moved on, response consumed
            held <= payload_t'('0);
        end
    end

endmodule

// File: mem_port/mem_port.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_port (
    input  logic                   clk,
    input  logic                   resetn,

    // client request
    input  logic                   need,
    input  logic [`MEM_ID_W-1:0]   id,
    input  logic                   wr,
    input  bus_pkg::size_t         size,
    input  logic [`MEM_ADDR_W-1:0] addr,
    input  logic [`MEM_DATA_W-1:0] wdata,
    input  logic                   stall,
    input  logic                   flush,

    // client response
    output logic                   busy,
    output logic [`MEM_DATA_W-1:0] rdata,
    output exc_pkg::mem_exc_t      exc,

    // towards the arbiter
    output logic                   req,
    output logic                   req_wr,
    output bus_pkg::size_t         req_size,
    output logic [`MEM_ADDR_W-1:0] req_addr,
    output logic [`MEM_DATA_W-1:0] req_wdata,
    input  logic                   addr_ok,
    input  logic                   data_ok,
    input  logic [`MEM_DATA_W-1:0] bus_rdata,
    input  exc_pkg::mem_exc_t      bus_exc
);

    // fields ride along, only req is qualified
    assign req_wr    = wr;
    assign req_size  = size;
    assign req_addr  = addr;
    assign req_wdata = wdata;

    sram_handshake handshake (
        .clk     (clk),
        .resetn  (resetn),
        .need    (need),
        .id      (id),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .req     (req),
        .busy    (busy)
    );

    resp_latch #(
        .payload_t (logic [`MEM_DATA_W-1:0])
    ) rdata_latch (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (stall),
        .flush   (flush),
        .data_ok (data_ok),
        .in      (bus_rdata),
        .out     (rdata)
    );

    resp_latch #(
        .payload_t (exc_pkg::mem_exc_t)
    ) exc_latch (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (stall),
        .flush   (flush),
        .data_ok (data_ok),
        .in      (bus_exc),
        .out     (exc)
    );

endmodule

// File: source/bus_arbiter.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module bus_arbiter (
    input  logic                   clk,
    input  logic                   resetn,

    // fetch port
    input  logic                   i_req,
    input  logic                   i_wr,
    input  bus_pkg::size_t         i_size,
    input  logic [`MEM_ADDR_W-1:0] i_addr,
    input  logic [`MEM_DATA_W-1:0] i_wdata,
    output logic                   i_addr_ok,
    output logic                   i_data_ok,

    // load/store port
    input  logic                   d_req,
    input  logic                   d_wr,
    input  bus_pkg::size_t         d_size,
    input  logic [`MEM_ADDR_W-1:0] d_addr,
    input  logic [`MEM_DATA_W-1:0] d_wdata,
    output logic                   d_addr_ok,
    output logic                   d_data_ok,

    // shared bus
    output logic                   bus_req,
    output logic                   bus_wr,
    output bus_pkg::size_t         bus_size,
    output logic [`MEM_ADDR_W-1:0] bus_addr,
    output logic [`MEM_DATA_W-1:0] bus_wdata,
    input  logic                   bus_addr_ok,
    input  logic                   bus_data_ok
);

    bus_pkg::grant_t grant;
    logic            addr_acc;
    logic            sel_req;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            grant    <= bus_pkg::GRANT_NONE;
            addr_acc <= 1'b0;
        end else if (grant == bus_pkg::GRANT_NONE) begin
            // load/store first, it usually holds up more of the pipe
            if (d_req) begin
                grant <= bus_pkg::GRANT_DATA;
            end else if (i_req) begin
                grant <= bus_pkg::GRANT_INST;
            end
        end else if (addr_acc) begin
            if (bus_data_ok) begin
                grant    <= bus_pkg::GRANT_NONE;
                addr_acc <= 1'b0;
            end
        end else if (bus_req && bus_addr_ok) begin
            addr_acc <= 1'b1;
        end
    end

    always_comb begin
        case (grant)
            bus_pkg::GRANT_INST: begin
                sel_req   = i_req;
                bus_wr    = i_wr;
                bus_size  = i_size;
                bus_addr  = i_addr;
                bus_wdata = i_wdata;
            end
            bus_pkg::GRANT_DATA: begin
                sel_req   = d_req;
                bus_wr    = d_wr;
                bus_size  = d_size;
                bus_addr  = d_addr;
                bus_wdata = d_wdata;
            end
            default: begin
                sel_req   = 1'b0;
                bus_wr    = 1'b0;
                bus_size  = bus_pkg::SIZE_WORD;
                bus_addr  = '0;
                bus_wdata = '0;
            end
        endcase
    end

    assign bus_req = sel_req && !addr_acc;

    // handshake goes back only to the owner
    assign i_addr_ok = (grant == bus_pkg::GRANT_INST) && bus_req && bus_addr_ok;
    assign d_addr_ok = (grant == bus_pkg::GRANT_DATA) && bus_req && bus_addr_ok;
    assign i_data_ok = (grant == bus_pkg::GRANT_INST) && addr_acc && bus_data_ok;
    assign d_data_ok = (grant == bus_pkg::GRANT_DATA) && addr_acc && bus_data_ok;

    // owner keeps the request and its fields steady until the slave takes it
    property bus_req_held_stable;
        @(posedge clk) disable iff (!resetn)
            bus_req && !bus_addr_ok |=> bus_req && $stable(bus_addr) && $stable(bus_wr)
                && $stable(bus_size) && $stable(bus_wdata);
    endproperty
    assert property (bus_req_held_stable)
        else $error("bus_arbiter: bus_req or its fields changed before addr_ok");

    // slave must answer only after taking the address
    property data_ok_after_addr;
        @(posedge clk) disable iff (!resetn)
            bus_data_ok |-> addr_acc;
    endproperty
    assert property (data_ok_after_addr)
        else $error("bus_arbiter: data_ok before the address was accepted");

endmodule

// File: source/mem_front_top.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_front_top (
    input  logic                   clk,
    input  logic                   resetn,

    // instruction fetch client
    input  logic                   inst_need,
    input  logic [`MEM_ID_W-1:0]   inst_id,
    input  logic [`MEM_ADDR_W-1:0] inst_addr,
    input  logic                   inst_stall,
    input  logic                   inst_flush,
    output logic                   inst_busy,
    output logic [`MEM_DATA_W-1:0] inst_rdata,
    output exc_pkg::mem_exc_t      inst_exc,

    // load/store client
    input  logic                   data_need,
    input  logic [`MEM_ID_W-1:0]   data_id,
    input  logic                   data_wr,
    input  bus_pkg::size_t         data_size,
    input  logic [`MEM_ADDR_W-1:0] data_addr,
    input  logic [`MEM_DATA_W-1:0] data_wdata,
    input  logic                   data_stall,
    input  logic                   data_flush,
    output logic                   data_busy,
    output logic [`MEM_DATA_W-1:0] data_rdata,
    output exc_pkg::mem_exc_t      data_exc,

    // shared sram-like bus
    output logic                   bus_req,
    output logic                   bus_wr,
    output bus_pkg::size_t         bus_size,
    output logic [`MEM_ADDR_W-1:0] bus_addr,
    output logic [`MEM_DATA_W-1:0] bus_wdata,
    input  logic                   bus_addr_ok,
    input  logic                   bus_data_ok,
    input  logic [`MEM_DATA_W-1:0] bus_rdata,
    input  exc_pkg::mem_exc_t      bus_exc
);

    logic                   i_req;
    logic                   i_wr;
    bus_pkg::size_t         i_size;
    logic [`MEM_ADDR_W-1:0] i_addr;
    logic [`MEM_DATA_W-1:0] i_wdata;
    logic                   i_addr_ok;
    logic                   i_data_ok;
    logic                   d_req;
    logic                   d_wr;
    bus_pkg::size_t         d_size;
    logic [`MEM_ADDR_W-1:0] d_addr;
    logic [`MEM_DATA_W-1:0] d_wdata;
    logic                   d_addr_ok;
    logic                   d_data_ok;

    // fetch is always a word read
    mem_port fetch_port (
        .clk (clk), .resetn (resetn),
        .need (inst_need), .id (inst_id), .wr (1'b0), .size (bus_pkg::SIZE_WORD),
        .addr (inst_addr), .wdata ('0), .stall (inst_stall), .flush (inst_flush),
        .busy (inst_busy), .rdata (inst_rdata), .exc (inst_exc),
        .req (i_req), .req_wr (i_wr), .req_size (i_size),
        .req_addr (i_addr), .req_wdata (i_wdata),
        .addr_ok (i_addr_ok), .data_ok (i_data_ok),
        .bus_rdata (bus_rdata), .bus_exc (bus_exc)
    );

    mem_port mem_stage_port (
        .clk (clk), .resetn (resetn),
        .need (data_need), .id (data_id), .wr (data_wr), .size (data_size),
        .addr (data_addr), .wdata (data_wdata), .stall (data_stall), .flush (data_flush),
        .busy (data_busy), .rdata (data_rdata), .exc (data_exc),
        .req (d_req), .req_wr (d_wr), .req_size (d_size),
        .req_addr (d_addr), .req_wdata (d_wdata),
        .addr_ok (d_addr_ok), .data_ok (d_data_ok),
        .bus_rdata (bus_rdata), .bus_exc (bus_exc)
    );

    bus_arbiter arbiter (
        .clk (clk), .resetn (resetn),
        .i_req (i_req), .i_wr (i_wr), .i_size (i_size), .i_addr (i_addr),
        .i_wdata (i_wdata), .i_addr_ok (i_addr_ok), .i_data_ok (i_data_ok),
        .d_req (d_req), .d_wr (d_wr), .d_size (d_size), .d_addr (d_addr),
        .d_wdata (d_wdata), .d_addr_ok (d_addr_ok), .d_data_ok (d_data_ok),
        .bus_req (bus_req), .bus_wr (bus_wr), .bus_size (bus_size),
        .bus_addr (bus_addr), .bus_wdata (bus_wdata),
        .bus_addr_ok (bus_addr_ok), .bus_data_ok (bus_data_ok)
    );

endmodule

// File: verification/sram_slave_model.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module sram_slave_model #(
    parameter logic [`MEM_ADDR_W-1:0] fault_base = 32'h0000_1000
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   bus_req,
    input  logic                   bus_wr,
    input  bus_pkg::size_t         bus_size,
    input  logic [`MEM_ADDR_W-1:0] bus_addr,
    input  logic [`MEM_DATA_W-1:0] bus_wdata,
    output logic                   bus_addr_ok,
    output logic                   bus_data_ok,
    output logic [`MEM_DATA_W-1:0] bus_rdata,
    output exc_pkg::mem_exc_t      bus_exc,
    output int                     txn_count,
    output int                     overlap_count
);

    // filled from the testbench before reset is released
    logic [`MEM_DATA_W-1:0] mem [0:1023];

    logic                   pending;
    int                     addr_wait;
    int                     data_wait;
    logic                   cur_wr;
    bus_pkg::size_t         cur_size;
    logic [`MEM_ADDR_W-1:0] cur_addr;
    logic [`MEM_DATA_W-1:0] cur_wdata;
    exc_pkg::mem_exc_t      status;
    logic [9:0]             idx;

    function automatic exc_pkg::mem_exc_t addr_status(
        input logic [`MEM_ADDR_W-1:0] a,
        input bus_pkg::size_t         s
    );
        if ((s == bus_pkg::SIZE_HALF && a[0])
                || (s == bus_pkg::SIZE_WORD && a[1:0] != 2'b00)) begin
            return exc_pkg::ADDR_ERR;
        end
        if (a >= fault_base) begin
            return exc_pkg::BUS_ERR;
        end
        return exc_pkg::NO_EXC;
    endfunction

    // byte lane b is written for this size and offset
    function automatic logic lane_on(input bus_pkg::size_t s, input logic [1:0] lo, input int b);
        case (s)
            bus_pkg::SIZE_BYTE: return b == lo;
            bus_pkg::SIZE_HALF: return (b / 2) == lo[1];
            default:            return 1'b1;
        endcase
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            bus_addr_ok   <= 1'b0;
            bus_data_ok   <= 1'b0;
            bus_rdata     <= '0;
            bus_exc       <= exc_pkg::NO_EXC;
            pending       <= 1'b0;
            addr_wait     <= $urandom_range(0, 3);
            data_wait     <= 0;
            txn_count     <= 0;
            overlap_count <= 0;
        end else begin
            bus_data_ok <= 1'b0;
            if (bus_req && (pending || bus_data_ok)) begin
                overlap_count <= overlap_count + 1;
                $display("slave: new bus_req at %0t while a transaction is outstanding", $time);
            end
            if (bus_req && bus_addr_ok) begin
                cur_wr      <= bus_wr;
                cur_size    <= bus_size;
                cur_addr    <= bus_addr;
                cur_wdata   <= bus_wdata;
                bus_addr_ok <= 1'b0;
                pending     <= 1'b1;
                data_wait   <= $urandom_range(0, 3);
                txn_count   <= txn_count + 1;
            end else if (bus_req && !pending && !bus_data_ok) begin
                if (addr_wait == 0) begin
                    bus_addr_ok <= 1'b1;
                end else begin
                    addr_wait <= addr_wait - 1;
                end
            end else if (!bus_req) begin
                addr_wait <= $urandom_range(0, 3);
            end
            if (pending) begin
                if (data_wait == 0) begin
                    status = addr_status(cur_addr, cur_size);
                    idx    = cur_addr[11:2];
                    pending     <= 1'b0;
                    bus_data_ok <= 1'b1;
                    bus_exc     <= status;
                    // faults and writes return zero data
                    bus_rdata   <= (status == exc_pkg::NO_EXC && !cur_wr) ? mem[idx] : '0;
                    if (status == exc_pkg::NO_EXC && cur_wr) begin
                        for (int b = 0; b < 4; b++) begin
                            if (lane_on(cur_size, cur_addr[1:0], b)) begin
                                mem[idx][8*b +: 8] <= cur_wdata[8*b +: 8];
                            end
                        end
                    end
                end else begin
                    data_wait <= data_wait - 1;
                end
            end
        end
    end

endmodule

// File: verification/tb_mem_front.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_front;

    localparam logic [`MEM_ADDR_W-1:0] FAULT_BASE = 32'h0000_1000;
    localparam int N_FETCH    = 8;
    localparam int N_PAIR     = 6;
    localparam int NUM_REQ    = N_FETCH + 6 * N_PAIR + 5;
    localparam int MAX_CYCLES = 60 * NUM_REQ + 100;

    logic                   clk;
    logic                   resetn;
    logic                   inst_need;
    logic [`MEM_ID_W-1:0]   inst_id;
    logic [`MEM_ADDR_W-1:0] inst_addr;
    logic                   inst_stall;
    logic                   inst_flush;
    logic                   inst_busy;
    logic [`MEM_DATA_W-1:0] inst_rdata;
    exc_pkg::mem_exc_t      inst_exc;
    logic                   data_need;
    logic [`MEM_ID_W-1:0]   data_id;
    logic                   data_wr;
    bus_pkg::size_t         data_size;
    logic [`MEM_ADDR_W-1:0] data_addr;
    logic [`MEM_DATA_W-1:0] data_wdata;
    logic                   data_stall;
    logic                   data_flush;
    logic                   data_busy;
    logic [`MEM_DATA_W-1:0] data_rdata;
    exc_pkg::mem_exc_t      data_exc;
    logic                   bus_req;
    logic                   bus_wr;
    bus_pkg::size_t         bus_size;
    logic [`MEM_ADDR_W-1:0] bus_addr;
    logic [`MEM_DATA_W-1:0] bus_wdata;
    logic                   bus_addr_ok;
    logic                   bus_data_ok;
    logic [`MEM_DATA_W-1:0] bus_rdata;
    exc_pkg::mem_exc_t      bus_exc;
    int                     txn_count;
    int                     overlap_count;

    // expected memory contents and per-port response tracking, 0 is fetch
    logic [`MEM_DATA_W-1:0] shadow [0:1023];
    logic                   busy_prev [2];
    logic                   hold [2];
    logic [`MEM_DATA_W-1:0] last_data [2];
    exc_pkg::mem_exc_t      last_exc [2];
    int                     word_errors;
    int                     exc_errors;
    int                     other_errors;
    int                     issued;
    int                     cycles;

    mem_front_top dut0 (.*);

    sram_slave_model #(.fault_base(FAULT_BASE)) slave0 (.*);

    always #10 clk = ~clk;

    // mixes every address bit into the word
    function automatic logic [`MEM_DATA_W-1:0] fill_word(input logic [`MEM_ADDR_W-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic void exp_read(
        input  logic [`MEM_ADDR_W-1:0] addr,
        input  bus_pkg::size_t         size,
        output logic [`MEM_DATA_W-1:0] data,
        output exc_pkg::mem_exc_t      exc
    );
        data = '0;
        if ((size == bus_pkg::SIZE_HALF && addr[0])
                || (size == bus_pkg::SIZE_WORD && addr[1:0] != 2'b00)) begin
            exc = exc_pkg::ADDR_ERR;
        end else if (addr >= FAULT_BASE) begin
            exc = exc_pkg::BUS_ERR;
        end else begin
            exc  = exc_pkg::NO_EXC;
            data = shadow[addr[11:2]];
        end
    endfunction

    task automatic write_shadow(
        input bus_pkg::size_t         size,
        input logic [`MEM_ADDR_W-1:0] addr,
        input logic [`MEM_DATA_W-1:0] wdata
    );
        for (int b = 0; b < 4; b++) begin
            if (size == bus_pkg::SIZE_WORD
                    || (size == bus_pkg::SIZE_HALF && b[1] == addr[1])
                    || (size == bus_pkg::SIZE_BYTE && b[1:0] == addr[1:0])) begin
                shadow[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    task automatic check_word(
        input string                  name,
        input logic [`MEM_DATA_W-1:0] exp,
        input logic [`MEM_DATA_W-1:0] act
    );
        if (act !== exp) begin
            word_errors = word_errors + 1;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_exc(
        input string             name,
        input exc_pkg::mem_exc_t exp,
        input exc_pkg::mem_exc_t act
    );
        if (act !== exp) begin
            exc_errors = exc_errors + 1;
            $display("error at %0t: %s expected %s, got %s (%0d)",
                     $time, name, exp.name(), act.name(), act);
        end
    endtask

    // bus serializes completions, so the shadow is updated in bus order
    task automatic track_port(
        input int                     p,
        input string                  name,
        input logic                   busy,
        input logic                   stall,
        input logic                   flush,
        input logic                   wr,
        input bus_pkg::size_t         size,
        input logic [`MEM_ADDR_W-1:0] addr,
        input logic [`MEM_DATA_W-1:0] wdata,
        input logic [`MEM_DATA_W-1:0] rdata,
        input exc_pkg::mem_exc_t      exc
    );
        logic [`MEM_DATA_W-1:0] exp_d;
        exc_pkg::mem_exc_t      exp_e;
        if (busy_prev[p] && !busy) begin
            exp_read(addr, size, exp_d, exp_e);
            if (wr) begin
                exp_d = '0;
                if (exp_e == exc_pkg::NO_EXC) begin
                    write_shadow(size, addr, wdata);
                end
            end
            check_word({name, "_rdata"}, exp_d, rdata);
            check_exc({name, "_exc"}, exp_e, exc);
            last_data[p] = exp_d;
            last_exc[p]  = exp_e;
            hold[p]      = 1'b1;
        end else if (hold[p]) begin
            check_word({name, "_rdata"}, last_data[p], rdata);
            check_exc({name, "_exc"}, last_exc[p], exc);
            if (flush) begin
                last_data[p] = '0;
                last_exc[p]  = exc_pkg::NO_EXC;
            end
            hold[p] = stall || flush;
        end
        busy_prev[p] = busy;
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            track_port(0, "inst", inst_busy, inst_stall, inst_flush, 1'b0, bus_pkg::SIZE_WORD,
                       inst_addr, '0, inst_rdata, inst_exc);
            track_port(1, "data", data_busy, data_stall, data_flush, data_wr, data_size,
                       data_addr, data_wdata, data_rdata, data_exc);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: requests still pending after %0d cycles", cycles);
            $display("errors: rdata %0d, exc %0d, other %0d",
                     word_errors, exc_errors, other_errors + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [`MEM_ADDR_W-1:0] pick_addr(input bus_pkg::size_t size);
        logic [`MEM_ADDR_W-1:0] a;
        a = $urandom_range(0, 1023) << 2;
        if (size == bus_pkg::SIZE_BYTE) begin
            a[1:0] = $urandom_range(0, 3);
        end else if (size == bus_pkg::SIZE_HALF) begin
            a[1] = $urandom_range(0, 1);
        end
        return a;
    endfunction

    task automatic fetch_word(input logic [`MEM_ADDR_W-1:0] addr, input int stall_len);
        @(negedge clk);
        inst_id   = inst_id + 1;
        inst_addr = addr;
        inst_need = 1'b1;
        issued    = issued + 1;
        do @(negedge clk); while (inst_busy);
        inst_stall = (stall_len > 0);
        repeat (stall_len) @(negedge clk);
        inst_stall = 1'b0;
        inst_need  = 1'b0;
    endtask

    task automatic data_access(
        input logic                   wr,
        input bus_pkg::size_t         size,
        input logic [`MEM_ADDR_W-1:0] addr,
        input logic [`MEM_DATA_W-1:0] wdata,
        input int                     stall_len,
        input logic                   flush
    );
        @(negedge clk);
        data_id    = data_id + 1;
        data_wr    = wr;
        data_size  = size;
        data_addr  = addr;
        data_wdata = wdata;
        data_need  = 1'b1;
        issued     = issued + 1;
        do @(negedge clk); while (data_busy);
        data_stall = (stall_len > 0) || flush;
        if (flush) begin
            // one cycle showing the held response, then clear it
            @(negedge clk);
            data_flush = 1'b1;
            @(negedge clk);
            data_flush = 1'b0;
        end
        repeat (stall_len) @(negedge clk);
        data_stall = 1'b0;
        data_need  = 1'b0;
    endtask

    initial begin
        int unsigned             first_draw;
        bus_pkg::size_t          sz;
        logic [`MEM_ADDR_W-1:0]  a;
        first_draw = $urandom(32'h1d4d_fa20);
        clk        = 1'b0;
        resetn     = 1'b0;
        inst_need  = 1'b0;
        inst_id    = '0;
        inst_addr  = '0;
        inst_stall = 1'b0;
        inst_flush = 1'b0;
        data_need  = 1'b0;
        data_id    = '0;
        data_wr    = 1'b0;
        data_size  = bus_pkg::SIZE_WORD;
        data_addr  = '0;
        data_wdata = '0;
        data_stall = 1'b0;
        data_flush = 1'b0;
        word_errors  = 0;
        exc_errors   = 0;
        other_errors = 0;
        issued       = 0;
        cycles       = 0;
        for (int p = 0; p < 2; p++) begin
            busy_prev[p] = 1'b0;
            hold[p]      = 1'b0;
        end
        for (int i = 0; i < 1024; i++) begin
            shadow[i]      = fill_word(i << 2);
            slave0.mem[i]  = fill_word(i << 2);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // fetch alone
        repeat (N_FETCH) fetch_word(pick_addr(bus_pkg::SIZE_WORD), 0);

        // write then read back, all sizes
        for (int i = 0; i < N_PAIR; i++) begin
            sz = bus_pkg::size_t'(i % 3);
            a  = pick_addr(sz);
            data_access(1'b1, sz, a, $urandom, 0, 1'b0);
            data_access(1'b0, sz, a, '0, 0, 1'b0);
        end

        // both ports competing for the bus
        fork
            repeat (N_PAIR) fetch_word(pick_addr(bus_pkg::SIZE_WORD), 0);
            repeat (N_PAIR) data_access($urandom_range(0, 1), bus_pkg::SIZE_WORD,
                                        pick_addr(bus_pkg::SIZE_WORD), $urandom, 0, 1'b0);
        join

        // stalls after completion
        fork
            repeat (N_PAIR) fetch_word(pick_addr(bus_pkg::SIZE_WORD), $urandom_range(1, 4));
            repeat (N_PAIR) data_access(1'b0, bus_pkg::SIZE_WORD, pick_addr(bus_pkg::SIZE_WORD),
                                        '0, $urandom_range(1, 4), 1'b0);
        join

        // misaligned and faulting accesses, data side flushed afterwards
        data_access(1'b0, bus_pkg::SIZE_HALF, pick_addr(bus_pkg::SIZE_WORD) | 1, '0, 0, 1'b1);
        data_access(1'b1, bus_pkg::SIZE_WORD, pick_addr(bus_pkg::SIZE_WORD) | 2, $urandom, 0, 1'b1);
        data_access(1'b0, bus_pkg::SIZE_WORD, FAULT_BASE + pick_addr(bus_pkg::SIZE_WORD),
                    '0, 0, 1'b1);
        fetch_word(FAULT_BASE + pick_addr(bus_pkg::SIZE_WORD), 0);
        fetch_word(pick_addr(bus_pkg::SIZE_WORD) | 2, 0);

        repeat (5) @(negedge clk);
        if (txn_count != issued) begin
            other_errors = other_errors + 1;
            $display("slave saw %0d bus transactions for %0d request ids", txn_count, issued);
        end
        if (overlap_count != 0) begin
            other_errors = other_errors + 1;
            $display("bus_req was issued %0d times with a transaction outstanding",
                     overlap_count);
        end
        $display("errors: rdata %0d, exc %0d, other %0d", word_errors, exc_errors, other_errors);
        if (word_errors + exc_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/bus_pkg.sv
common/exc_pkg.sv
mem_port/sram_handshake.sv
mem_port/resp_latch.sv
mem_port/mem_port.sv
source/bus_arbiter.sv
source/mem_front_top.sv
verification/sram_slave_model.sv
verification/tb_mem_front.sv
